//--- verilog.f
+incdir+tb
source/cpu_pkg.sv
source/alu.sv
source/decoder.sv
source/register_file.sv
source/core_control.sv
source/mem.sv
source/leds.sv
source/cpu_top.sv
tb/tb_cpu_top.sv

//--- Makefile
SIM := obj_dir/Vtb_cpu_top

$(SIM): verilog.f $(wildcard source/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module tb_cpu_top

.PHONY: run clean

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- tb/cpu_iss.svh
// Instruction-set model of the core, run on the boot image to predict LED writes and halt
`ifndef CPU_ISS_SVH
`define CPU_ISS_SVH

// Included inside the testbench module, reads the program image prog
localparam int STEP_LIMIT = 10000;

logic [15:0] model_mem [MEM_WORDS];
logic [7:0]  exp_leds [$];
logic        exp_halt;

task automatic run_model();
    logic [15:0]      r [8];
    logic [15:0]      pc;
    logic [15:0]      pc_next;
    logic [15:0]      link;
    logic [15:0]      w;
    logic [15:0]      simm;
    logic [2:0]       rd;
    logic [2:0]       rs;
    logic             zf;
    cpu_pkg::opcode_e op;
    for (int i = 0; i < MEM_WORDS; i++) begin
        model_mem[i] = prog[i];
    end
    for (int i = 0; i < 8; i++) begin
        r[i] = 16'd0;
    end
    pc   = 16'd0;
    link = 16'd0;
    zf   = 1'b0;
    exp_leds.delete();
    exp_halt = 1'b0;
    for (int step = 0; step < STEP_LIMIT && !exp_halt; step++) begin
        w       = model_mem[pc[AW-1:0]];
        op      = cpu_pkg::opcode_e'(w[15:12]);
        rd      = w[11:9];
        rs      = w[8:6];
        simm    = {{7{w[8]}}, w[8:0]};
        pc_next = pc + 16'd1;
        case (op)
            cpu_pkg::OP_ADD: begin
                r[rd] = r[rd] + r[rs];
                zf    = (r[rd] == 16'd0);
            end
            cpu_pkg::OP_SUB: begin
                r[rd] = r[rd] - r[rs];
                zf    = (r[rd] == 16'd0);
            end
            cpu_pkg::OP_AND: begin
                r[rd] = r[rd] & r[rs];
                zf    = (r[rd] == 16'd0);
            end
            cpu_pkg::OP_OR: begin
                r[rd] = r[rd] | r[rs];
                zf    = (r[rd] == 16'd0);
            end
            cpu_pkg::OP_XOR: begin
                r[rd] = r[rd] ^ r[rs];
                zf    = (r[rd] == 16'd0);
            end
            cpu_pkg::OP_ADDI: begin
                r[rd] = r[rd] + simm;
                zf    = (r[rd] == 16'd0);
            end
            cpu_pkg::OP_LDI: r[rd] = simm;  // Flag untouched
            cpu_pkg::OP_LD:  r[rd] = model_mem[r[rs][AW-1:0]];
            cpu_pkg::OP_ST: begin
                if (r[rd] == 16'hFFFF) begin
                    exp_leds.push_back(r[rs][7:0]);
                end else begin
                    model_mem[r[rd][AW-1:0]] = r[rs];
                end
            end
            cpu_pkg::OP_BZ:  if (zf) pc_next = pc + 16'd1 + simm;
            cpu_pkg::OP_BNZ: if (!zf) pc_next = pc + 16'd1 + simm;
            cpu_pkg::OP_JAL: begin
                link    = pc + 16'd1;
                pc_next = pc + 16'd1 + simm;
            end
            cpu_pkg::OP_RET:  pc_next = link;
            cpu_pkg::OP_HALT: exp_halt = 1'b1;
            default: ;
        endcase
        pc = pc_next;
    end
endtask

`endif

//--- tb/tb_cpu_top.sv
// Testbench for cpu_top with random programs, boot loading and model-checked LED writes
`default_nettype none

module tb_cpu_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS    = 256;
    localparam int AW           = $clog2(MEM_WORDS);
    localparam int DATA_BASE    = MEM_WORDS - 64;  // Scratch words for LD and ST
    localparam int PROG_LIMIT   = DATA_BASE - 40;
    localparam int NUM_PROGRAMS = 5;
    localparam int RUN_TIMEOUT  = 20000;

    logic        clk;
    logic        rst_n;
    logic        boot_we;
    logic [15:0] boot_addr;
    logic [15:0] boot_data;
    logic [7:0]  led;
    logic        led_strobe;
    logic        halted;

    integer      seed;
    logic [15:0] prog [MEM_WORDS];
    int          plen;
    int          unit_start [$];
    int          br_pos [$];
    int          br_unit [$];

    `include "cpu_iss.svh"

    cpu_top #(
        .MEM_WORDS (MEM_WORDS)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .boot_we    (boot_we),
        .boot_addr  (boot_addr),
        .boot_data  (boot_data),
        .led        (led),
        .led_strobe (led_strobe),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: led is %02h, expected %02h", $time, got, exp));
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: led_strobe is %b, expected %b",
                               $time, got, exp));
        end
    endtask

    task automatic check_halt(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: halted is %b, expected %b", $time, got, exp));
        end
    endtask

    function automatic int pick(input int n);
        pick = int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [15:0] enc_rr(input cpu_pkg::opcode_e op,
                                           input logic [2:0] rd, input logic [2:0] rs);
        enc_rr = {op, rd, rs, 6'b0};
    endfunction

    function automatic logic [15:0] enc_ri(input cpu_pkg::opcode_e op,
                                           input logic [2:0] rd, input logic [8:0] imm);
        enc_ri = {op, rd, imm};
    endfunction

    task automatic emit(input logic [15:0] w);
        prog[plen] = w;
        plen = plen + 1;
    endtask

    // Data op on r0..r6 only so r7 keeps the store address
    task automatic emit_alu();
        int kind;
        kind = pick(7);
        if (kind < 5) begin
            emit(enc_rr(cpu_pkg::opcode_e'(kind), 3'(pick(7)), 3'(pick(8))));
        end else if (kind == 5) begin
            emit(enc_ri(cpu_pkg::OP_ADDI, 3'(pick(7)), 9'(pick(512))));
        end else begin
            emit(enc_ri(cpu_pkg::OP_LDI, 3'(pick(7)), 9'(pick(512))));
        end
    endtask

    // Store to a scratch word, load back and show it on the LEDs
    task automatic emit_round_trip();
        logic [2:0] src;
        logic [2:0] dst;
        src = 3'(pick(7));
        dst = 3'(pick(7));
        emit(enc_ri(cpu_pkg::OP_LDI, 3'd7, 9'(DATA_BASE + pick(63))));
        emit(enc_rr(cpu_pkg::OP_ST, 3'd7, src));
        emit(enc_rr(cpu_pkg::OP_LD, dst, 3'd7));
        emit(enc_ri(cpu_pkg::OP_LDI, 3'd7, 9'h1ff));  // Back to LED_ADDR
        emit(enc_rr(cpu_pkg::OP_ST, 3'd7, dst));
    endtask

    // Call into a body ending in RET that returns onto a store to the LEDs
    task automatic emit_call();
        int jpos;
        int body;
        body = 1 + pick(4);
        emit(enc_ri(cpu_pkg::OP_JAL, 3'd0, 9'd2));
        emit(enc_rr(cpu_pkg::OP_ST, 3'd7, 3'(pick(8))));  // Reached only through the return
        jpos = plen;
        emit(enc_ri(cpu_pkg::OP_JAL, 3'd0, 9'd0));  // Jumps past the body
        for (int i = 0; i < body; i++) begin
            if (pick(2) == 0) emit_alu();
            else emit(enc_rr(cpu_pkg::OP_ST, 3'd7, 3'(pick(8))));
        end
        emit(enc_ri(cpu_pkg::OP_RET, 3'd0, 9'd0));
        prog[jpos][8:0] = 9'(plen - (jpos + 1));
    endtask

    task automatic gen_program();
        int units;
        int kind;
        int span;
        int tgt;
        plen = 0;
        unit_start.delete();
        br_pos.delete();
        br_unit.delete();
        emit(enc_ri(cpu_pkg::OP_LDI, 3'd7, 9'h1ff));  // r7 = LED_ADDR
        units = 20 + pick(20);
        for (int u = 0; u < units && plen < PROG_LIMIT; u++) begin
            unit_start.push_back(plen);
            kind = pick(10);
            if (kind < 3) begin
                emit_alu();
            end else if (kind < 6) begin
                emit(enc_rr(cpu_pkg::OP_ST, 3'd7, 3'(pick(8))));
            end else if (kind == 6) begin
                emit_round_trip();
            end else if (kind == 7) begin
                br_pos.push_back(plen);
                br_unit.push_back(unit_start.size());
                emit(enc_ri(cpu_pkg::opcode_e'(pick(2) == 0 ? cpu_pkg::OP_BZ : cpu_pkg::OP_BNZ),
                            3'd0, 9'd0));
            end else if (kind == 8) begin
                emit_call();
            end else begin
                emit(enc_rr(cpu_pkg::OP_LD, 3'(pick(7)), 3'(pick(8))));
            end
        end
        unit_start.push_back(plen);
        emit(enc_ri(cpu_pkg::OP_HALT, 3'd0, 9'd0));
        // Forward branches onto the start of a later unit
        foreach (br_pos[i]) begin
            span = unit_start.size() - br_unit[i];
            if (span > 4) span = 4;
            tgt = br_unit[i] + pick(span);
            prog[br_pos[i]][8:0] = 9'(unit_start[tgt] - (br_pos[i] + 1));
        end
        for (int a = plen; a < MEM_WORDS; a++) begin
            prog[a] = 16'(a * 32'h9e37) ^ 16'h5a3c;
        end
    endtask

    task automatic load_and_reset();
        @(negedge clk);
        rst_n = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            @(negedge clk);
            boot_we   = 1'b1;
            boot_addr = 16'(a);
            boot_data = prog[a];
        end
        @(negedge clk);
        boot_we = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_led(led, 8'h00);
        check_strobe(led_strobe, 1'b0);
        check_halt(halted, 1'b0);
    endtask

    task automatic watch_run();
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (led_strobe === 1'b1) begin
                if (exp_leds.size() == 0) fail_run("LED strobe seen with no write left in the model");
                else check_led(led, exp_leds.pop_front());
            end
            if (halted === 1'b1) begin
                done = 1'b1;
            end else if (cycles >= RUN_TIMEOUT) begin
                fail_run("timed out waiting for the core to halt");
            end
        end
        check_halt(halted, exp_halt);
        if (exp_leds.size() != 0) fail_run("core halted before all expected LED writes");
        repeat (3) begin
            @(negedge clk);
            check_strobe(led_strobe, 1'b0);
            check_halt(halted, 1'b1);  // Sticky until reset
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        boot_we   = 1'b0;
        boot_addr = 16'd0;
        boot_data = 16'd0;
        seed      = 32'h1a9a_c754;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            gen_program();
            run_model();
            load_and_reset();
            watch_run();
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/cpu_top.sv
// Top level joining the core, memory and LED register
`default_nettype none

module cpu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        boot_we,
    input  logic [15:0] boot_addr,
    input  logic [15:0] boot_data,
    output logic [7:0]  led,
    output logic        led_strobe,
    output logic        halted
);

    cpu_pkg::mem_req_t mem_req;
    logic [15:0]       rdata;
    logic              mem_wait;

    core_control u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_req  (mem_req),
        .rdata    (rdata),
        .mem_wait (mem_wait),
        .halted   (halted)
    );

    mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .boot_we   (boot_we),
        .boot_addr (boot_addr),
        .boot_data (boot_data),
        .req       (mem_req),
        .rdata     (rdata),
        .mem_wait  (mem_wait)
    );

    // Shares the request and wait with memory
    leds u_leds (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (mem_req),
        .mem_wait   (mem_wait),
        .led        (led),
        .led_strobe (led_strobe)
    );

endmodule

`default_nettype wire

//--- source/leds.sv
// Memory-mapped LED register with a one-cycle write strobe
`default_nettype none

module leds (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::mem_req_t req,
    input  logic              mem_wait,
    output logic [7:0]        led,
    output logic              led_strobe
);

    logic led_wr;

    // Only the completing cycle of a store counts
    assign led_wr = req.valid && req.write && !mem_wait && (req.addr == cpu_pkg::LED_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led        <= '0;
            led_strobe <= 1'b0;
        end else begin
            led_strobe <= led_wr;
            if (led_wr) led <= req.wdata[7:0];
        end
    end

endmodule

`default_nettype wire

//--- source/mem.sv
// Word memory with boot write port and one wait state per core access
`default_nettype none

module mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              boot_we,
    input  logic [15:0]       boot_addr,
    input  logic [15:0]       boot_data,
    input  cpu_pkg::mem_req_t req,
    output logic [15:0]       rdata,
    output logic              mem_wait
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [15:0] ram [MEM_WORDS];
    logic        second;  // Second cycle of a request
    logic        led_hit;

    assign mem_wait = req.valid && !second;
    assign led_hit  = (req.addr == cpu_pkg::LED_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            second <= 1'b0;
        end else begin
            second <= req.valid && !second;
        end
    end

    always_ff @(posedge clk) begin
        if (boot_we) begin
            ram[boot_addr[AW-1:0]] <= boot_data;  // Boot loader wins
        end else if (req.valid && req.write && second && !led_hit) begin
            ram[req.addr[AW-1:0]] <= req.wdata;
        end
        if (mem_wait) rdata <= ram[req.addr[AW-1:0]];  // Ready for the completing cycle
    end

endmodule

`default_nettype wire

//--- source/core_control.sv
// Multicycle sequencer with PC, instruction register, link register and zero flag
`default_nettype none

module core_control (
    input  logic              clk,
    input  logic              rst_n,
    output cpu_pkg::mem_req_t mem_req,
    input  logic [15:0]       rdata,
    input  logic              mem_wait,
    output logic              halted
);

    cpu_pkg::state_e    state;
    cpu_pkg::instr_u    ir;
    cpu_pkg::dec_ctrl_t ctrl;

    logic [15:0] pc;
    logic [15:0] pc_plus1;
    logic [15:0] link_q;
    logic [15:0] result_q;  // ALU result, branch target or load data
    logic        zero_q;
    logic        run;
    logic [15:0] rd_data;
    logic [15:0] rs_data;
    logic [15:0] alu_a;
    logic [15:0] alu_b;
    logic [15:0] alu_result;
    logic        alu_zero;
    logic        mem_done;
    logic        taken;
    logic        set_zero;
    logic        reg_wr_en;

    decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .decode_en (state == cpu_pkg::S_DECODE),
        .instr     (ir),
        .ctrl      (ctrl)
    );

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (reg_wr_en),
        .rd_sel  (ctrl.rd_sel),
        .rs_sel  (ctrl.rs_sel),
        .wdata   (result_q),
        .rd_data (rd_data),
        .rs_data (rs_data)
    );

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign pc_plus1 = pc + 16'd1;
    assign alu_a    = (ctrl.branch_z || ctrl.branch_nz || ctrl.link) ? pc_plus1 : rd_data;
    assign alu_b    = ctrl.use_imm ? ctrl.imm : rs_data;
    assign mem_done = mem_req.valid && !mem_wait;
    assign taken    = (ctrl.branch_z && zero_q) || (ctrl.branch_nz && !zero_q);
    assign set_zero = ctrl.reg_wr && !ctrl.mem_rd && (ctrl.alu_op != cpu_pkg::ALU_PASS_B);
    assign reg_wr_en = (state == cpu_pkg::S_WRITEBACK) && ctrl.reg_wr;
    assign halted   = (state == cpu_pkg::S_HALTED) ||
                      (state == cpu_pkg::S_EXECUTE && ctrl.halt);

    // Fetch reads at PC, memory state uses the address from execute
    always_comb begin
        mem_req       = '0;
        mem_req.valid = run && (state == cpu_pkg::S_FETCH || state == cpu_pkg::S_MEMORY);
        mem_req.addr  = pc;
        if (state == cpu_pkg::S_MEMORY) begin
            mem_req.write = ctrl.mem_wr;
            mem_req.addr  = result_q;
            mem_req.wdata = rs_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= cpu_pkg::S_FETCH;
            pc     <= '0;
            link_q <= '0;
            zero_q <= 1'b0;
            run    <= 1'b0;  // Requests start one cycle after reset
        end else begin
            run <= 1'b1;
            case (state)
                cpu_pkg::S_FETCH: if (mem_done) state <= cpu_pkg::S_DECODE;
                cpu_pkg::S_DECODE: state <= cpu_pkg::S_EXECUTE;
                cpu_pkg::S_EXECUTE: begin
                    if (set_zero) zero_q <= alu_zero;
                    if (ctrl.halt) state <= cpu_pkg::S_HALTED;
                    else if (ctrl.mem_rd || ctrl.mem_wr) state <= cpu_pkg::S_MEMORY;
                    else state <= cpu_pkg::S_WRITEBACK;
                end
                cpu_pkg::S_MEMORY: if (mem_done) state <= cpu_pkg::S_WRITEBACK;
                cpu_pkg::S_WRITEBACK: begin
                    if (ctrl.ret) begin
                        pc <= link_q;
                    end else if (taken || ctrl.link) begin
                        pc <= result_q;
                    end else begin
                        pc <= pc_plus1;
                    end
                    if (ctrl.link) link_q <= pc_plus1;
                    state <= cpu_pkg::S_FETCH;
                end
                default: ;  // Halted until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::S_FETCH && mem_done) ir <= rdata;
        if (state == cpu_pkg::S_EXECUTE) begin
            result_q <= alu_result;
        end else if (state == cpu_pkg::S_MEMORY && mem_done && ctrl.mem_rd) begin
            result_q <= rdata;
        end
    end

endmodule

`default_nettype wire

//--- source/register_file.sv
// Eight-entry register file, two combinational reads and one write
`default_nettype none

module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  logic [2:0]  rd_sel,
    input  logic [2:0]  rs_sel,
    input  logic [15:0] wdata,
    output logic [15:0] rd_data,
    output logic [15:0] rs_data
);

    logic [15:0] regs [8];

    // Writes always target rd
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_sel] <= wdata;
        end
    end

    assign rd_data = regs[rd_sel];
    assign rs_data = regs[rs_sel];

endmodule

`default_nettype wire

//--- source/decoder.sv
// Instruction decoder registering the control word for execute
`default_nettype none

module decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               decode_en,
    input  cpu_pkg::instr_u    instr,
    output cpu_pkg::dec_ctrl_t ctrl
);

    cpu_pkg::dec_ctrl_t nxt;
    logic [15:0]        imm_ext;

    assign imm_ext = {{7{instr.ri.imm[8]}}, instr.ri.imm};

    always_comb begin
        nxt        = '0;
        nxt.alu_op = cpu_pkg::ALU_ADD;
        nxt.rd_sel = instr.rr.rd;
        nxt.rs_sel = instr.rr.rs;
        case (instr.rr.op)
            cpu_pkg::OP_ADD: nxt.reg_wr = 1'b1;
            cpu_pkg::OP_SUB: begin
                nxt.alu_op = cpu_pkg::ALU_SUB;
                nxt.reg_wr = 1'b1;
            end
            cpu_pkg::OP_AND: begin
                nxt.alu_op = cpu_pkg::ALU_AND;
                nxt.reg_wr = 1'b1;
            end
            cpu_pkg::OP_OR: begin
                nxt.alu_op = cpu_pkg::ALU_OR;
                nxt.reg_wr = 1'b1;
            end
            cpu_pkg::OP_XOR: begin
                nxt.alu_op = cpu_pkg::ALU_XOR;
                nxt.reg_wr = 1'b1;
            end
            cpu_pkg::OP_ADDI: begin
                nxt.use_imm = 1'b1;
                nxt.imm     = imm_ext;
                nxt.reg_wr  = 1'b1;
            end
            cpu_pkg::OP_LDI: begin
                nxt.alu_op  = cpu_pkg::ALU_PASS_B;
                nxt.use_imm = 1'b1;
                nxt.imm     = imm_ext;
                nxt.reg_wr  = 1'b1;
            end
            cpu_pkg::OP_LD: begin
                nxt.alu_op = cpu_pkg::ALU_PASS_B;  // Address is rs
                nxt.reg_wr = 1'b1;
                nxt.mem_rd = 1'b1;
            end
            cpu_pkg::OP_ST: begin
                nxt.use_imm = 1'b1;  // Address is rd + 0
                nxt.mem_wr  = 1'b1;
            end
            cpu_pkg::OP_BZ: begin
                nxt.use_imm  = 1'b1;
                nxt.imm      = imm_ext;
                nxt.branch_z = 1'b1;
            end
            cpu_pkg::OP_BNZ: begin
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_ext;
                nxt.branch_nz = 1'b1;
            end
            cpu_pkg::OP_JAL: begin
                nxt.use_imm = 1'b1;
                nxt.imm     = imm_ext;
                nxt.link    = 1'b1;
            end
            cpu_pkg::OP_RET:  nxt.ret  = 1'b1;
            cpu_pkg::OP_HALT: nxt.halt = 1'b1;
            default: ;  // Spare opcodes act as no-ops
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else if (decode_en) begin
            ctrl <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- source/alu.sv
// ALU for data operations, load and store addresses and branch targets
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_e op,
    input  logic [15:0]      a,
    input  logic [15:0]      b,
    output logic [15:0]      result,
    output logic             zero
);

    // Branch targets arrive as a = PC + 1, b = offset, op = add
    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:    result = a + b;
            cpu_pkg::ALU_SUB:    result = a - b;
            cpu_pkg::ALU_AND:    result = a & b;
            cpu_pkg::ALU_OR:     result = a | b;
            cpu_pkg::ALU_XOR:    result = a ^ b;
            cpu_pkg::ALU_PASS_B: result = b;  // LDI value, LD address
            default:             result = '0;
        endcase
    end

    assign zero = (result == 16'd0);

endmodule

`default_nettype wire

//--- source/cpu_pkg.sv
// Shared opcodes, instruction word views, decoded control and memory request types
`default_nettype none

package cpu_pkg;

    // Store target of the LED register, never backed by memory
    localparam logic [15:0] LED_ADDR = 16'hFFFF;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd5,
        OP_LDI  = 4'd6,
        OP_LD   = 4'd7,
        OP_ST   = 4'd8,
        OP_BZ   = 4'd9,
        OP_BNZ  = 4'd10,
        OP_JAL  = 4'd11,
        OP_RET  = 4'd12,
        OP_HALT = 4'd13
    } opcode_e;

    // Register form
    typedef struct packed {
        opcode_e    op;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [5:0] pad;  // Ignored
    } rr_t;

    // Immediate form
    typedef struct packed {
        opcode_e    op;
        logic [2:0] rd;
        logic [8:0] imm;  // Signed
    } ri_t;

    typedef union packed {
        rr_t rr;
        ri_t ri;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        use_imm;
        logic [15:0] imm;        // Sign extended
        logic [2:0]  rd_sel;
        logic [2:0]  rs_sel;
        logic        reg_wr;
        logic        mem_rd;
        logic        mem_wr;
        logic        branch_z;
        logic        branch_nz;
        logic        link;
        logic        ret;
        logic        halt;
    } dec_ctrl_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [15:0] addr;
        logic [15:0] wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        S_FETCH     = 3'd0,
        S_DECODE    = 3'd1,
        S_EXECUTE   = 3'd2,
        S_MEMORY    = 3'd3,
        S_WRITEBACK = 3'd4,
        S_HALTED    = 3'd5
    } state_e;

endpackage

`default_nettype wire
